/* src/wbuf_pkg.sv */
// shared sizes, vector types and bus structs of the coalescing store buffer
// the rtl and the testbench refer to everything here by scoped name

package wbuf_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  // fully associative entries, one 64 bit word each
  localparam int WBUF_DEPTH        = 8;
  // transactions that may be in flight at once
  localparam int NUM_TX            = 4;
  localparam int ADDR_WIDTH        = 32;
  localparam int BYTES_PER_WORD    = 8;

  // derived widths
  localparam int WORD_OFFSET_WIDTH = $clog2(BYTES_PER_WORD);
  localparam int WORD_ADDR_WIDTH   = ADDR_WIDTH - WORD_OFFSET_WIDTH;
  localparam int WORD_WIDTH        = 8 * BYTES_PER_WORD;
  localparam int WBUF_PTR_WIDTH    = $clog2(WBUF_DEPTH);
  localparam int TX_ID_WIDTH       = $clog2(NUM_TX);

  //////////////////////////////
  // vector types
  //////////////////////////////

  // byte address without the offset inside the word
  typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;
  typedef logic [WORD_WIDTH-1:0]      word_data_t;
  // one bit per byte lane
  typedef logic [BYTES_PER_WORD-1:0]  byte_mask_t;
  typedef logic [WBUF_PTR_WIDTH-1:0]  wbuf_ptr_t;
  typedef logic [TX_ID_WIDTH-1:0]     tx_id_t;

  //////////////////////////////
  // structs
  //////////////////////////////

  // store coming from the core
  typedef struct packed {
    word_addr_t addr;
    word_data_t data;
    byte_mask_t mask;
  } store_req_t;

  // one buffer entry, the three masks give the state of each byte
  typedef struct packed {
    word_addr_t addr;
    word_data_t data;
    byte_mask_t valid;
    byte_mask_t dirty;
    // byte is part of a transaction in flight
    byte_mask_t txblock;
  } wbuf_entry_t;

  // intake write into one entry
  typedef struct packed {
    logic       en;
    wbuf_ptr_t  ptr;
    store_req_t req;
  } wbuf_write_t;

  // byte mask update, used for send-mark and for response clear
  typedef struct packed {
    logic       en;
    wbuf_ptr_t  ptr;
    byte_mask_t mask;
  } wbuf_mark_t;

  // outgoing memory write, id names the transaction slot
  typedef struct packed {
    tx_id_t     id;
    word_addr_t addr;
    word_data_t data;
    byte_mask_t mask;
  } mem_req_t;

  // bookkeeping for one outstanding transaction
  typedef struct packed {
    logic       valid;
    wbuf_ptr_t  ptr;
    byte_mask_t mask;
  } tx_slot_t;

endpackage

/* src/wbuf_store_intake.sv */
// store intake of the coalescing store buffer
// matches the incoming store against all buffered words and grants it in the
// same cycle when it hits or a free entry exists, then issues the array write

`timescale 1ns/100ps

module wbuf_store_intake (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            store_valid_i,
  input  wbuf_pkg::store_req_t                            store_req_i,
  input  wbuf_pkg::wbuf_entry_t [wbuf_pkg::WBUF_DEPTH-1:0] entries_i,
  output logic                                            store_gnt_o,
  output wbuf_pkg::wbuf_write_t                           wr_cmd_o
);

  logic [wbuf_pkg::WBUF_DEPTH-1:0] hit;
  logic [wbuf_pkg::WBUF_DEPTH-1:0] free;
  wbuf_pkg::wbuf_ptr_t             hit_ptr;
  wbuf_pkg::wbuf_ptr_t             free_ptr;
  logic                            any_hit;
  logic                            any_free;

  //////////////////////////////
  // address match
  //////////////////////////////

  for (genvar k = 0; k < wbuf_pkg::WBUF_DEPTH; k++) begin : gen_match
    // an entry without any valid byte is free
    assign free[k] = ~(|entries_i[k].valid);
    // only live entries take part in the compare
    assign hit[k]  = ~free[k] & (entries_i[k].addr == store_req_i.addr);
  end

  assign any_hit  = |hit;
  assign any_free = |free;

  // walk downward so the lowest index is taken last and wins
  always_comb begin : p_encode
    hit_ptr  = '0;
    free_ptr = '0;
    for (int k = wbuf_pkg::WBUF_DEPTH - 1; k >= 0; k--) begin
      if (hit[k]) begin
        hit_ptr = wbuf_pkg::wbuf_ptr_t'(k);
      end
      if (free[k]) begin
        free_ptr = wbuf_pkg::wbuf_ptr_t'(k);
      end
    end
  end

  //////////////////////////////
  // grant and write command
  //////////////////////////////

  // a hit always coalesces, a miss needs a free entry
  assign store_gnt_o  = store_valid_i & (any_hit | any_free);

  assign wr_cmd_o.en  = store_gnt_o;
  assign wr_cmd_o.ptr = any_hit ? hit_ptr : free_ptr;
  assign wr_cmd_o.req = store_req_i;

  //////////////////////////////
  // checks
  //////////////////////////////

  // a word lives in at most one entry, which relies on the array
  // only ever allocating a miss into a free entry
  a_hit_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    store_valid_i |-> $onehot0(hit)
  ) else $error("store address matches more than one buffer entry");

endmodule

/* src/wbuf_entry_array.sv */
// entry storage of the coalescing store buffer
// holds address, data and the valid/dirty/txblock byte masks of every entry
// and applies the response clear, the send-mark and the store write each cycle

`timescale 1ns/100ps

module wbuf_entry_array (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  wbuf_pkg::wbuf_write_t                            wr_cmd_i,
  input  wbuf_pkg::wbuf_mark_t                             send_mark_i,
  input  wbuf_pkg::wbuf_mark_t                             clear_mark_i,
  output wbuf_pkg::wbuf_entry_t [wbuf_pkg::WBUF_DEPTH-1:0] entries_o,
  output logic                                             empty_o
);

  // payload storage
  wbuf_pkg::word_addr_t addr_q [wbuf_pkg::WBUF_DEPTH];
  wbuf_pkg::word_data_t data_q [wbuf_pkg::WBUF_DEPTH];

  // per byte state
  wbuf_pkg::byte_mask_t [wbuf_pkg::WBUF_DEPTH-1:0] valid_q;
  wbuf_pkg::byte_mask_t [wbuf_pkg::WBUF_DEPTH-1:0] valid_d;
  wbuf_pkg::byte_mask_t [wbuf_pkg::WBUF_DEPTH-1:0] dirty_q;
  wbuf_pkg::byte_mask_t [wbuf_pkg::WBUF_DEPTH-1:0] dirty_d;
  wbuf_pkg::byte_mask_t [wbuf_pkg::WBUF_DEPTH-1:0] txblock_q;
  wbuf_pkg::byte_mask_t [wbuf_pkg::WBUF_DEPTH-1:0] txblock_d;

  //////////////////////////////
  // byte state update
  //////////////////////////////

  // order matters: clear, then send-mark, then the store write on top
  always_comb begin : p_state
    valid_d   = valid_q;
    dirty_d   = dirty_q;
    txblock_d = txblock_q;

    // response returned, bytes written again meanwhile stay for a resend
    if (clear_mark_i.en) begin
      txblock_d[clear_mark_i.ptr] = txblock_q[clear_mark_i.ptr] & ~clear_mark_i.mask;
      valid_d[clear_mark_i.ptr]   = valid_q[clear_mark_i.ptr] &
                                    ~(clear_mark_i.mask & ~dirty_q[clear_mark_i.ptr]);
    end

    // bytes handed to memory are no longer dirty but in flight
    if (send_mark_i.en) begin
      dirty_d[send_mark_i.ptr]   = dirty_d[send_mark_i.ptr] & ~send_mark_i.mask;
      txblock_d[send_mark_i.ptr] = txblock_d[send_mark_i.ptr] | send_mark_i.mask;
    end

    // a store in the send cycle leaves the byte dirty and in flight
    if (wr_cmd_i.en) begin
      valid_d[wr_cmd_i.ptr] = valid_d[wr_cmd_i.ptr] | wr_cmd_i.req.mask;
      dirty_d[wr_cmd_i.ptr] = dirty_d[wr_cmd_i.ptr] | wr_cmd_i.req.mask;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state_regs
    if (!rst_ni) begin
      valid_q   <= '0;
      dirty_q   <= '0;
      txblock_q <= '0;
    end else begin
      valid_q   <= valid_d;
      dirty_q   <= dirty_d;
      txblock_q <= txblock_d;
    end
  end

  //////////////////////////////
  // payload write
  //////////////////////////////

  // byte merge into the target word
  always_ff @(posedge clk_i) begin : p_payload
    if (wr_cmd_i.en) begin
      addr_q[wr_cmd_i.ptr] <= wr_cmd_i.req.addr;
      for (int b = 0; b < wbuf_pkg::BYTES_PER_WORD; b++) begin
        if (wr_cmd_i.req.mask[b]) begin
          data_q[wr_cmd_i.ptr][b*8 +: 8] <= wr_cmd_i.req.data[b*8 +: 8];
        end
      end
    end
  end

  //////////////////////////////
  // outputs and checks
  //////////////////////////////

  for (genvar k = 0; k < wbuf_pkg::WBUF_DEPTH; k++) begin : gen_out
    assign entries_o[k].addr    = addr_q[k];
    assign entries_o[k].data    = data_q[k];
    assign entries_o[k].valid   = valid_q[k];
    assign entries_o[k].dirty   = dirty_q[k];
    assign entries_o[k].txblock = txblock_q[k];

    // legal byte states are 000, 110, 101 and 111 (valid/dirty/txblock)
    // so a dead byte carries no flags and a live byte is dirty or in flight
    a_byte_state : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      ((~valid_q[k] & (dirty_q[k] | txblock_q[k])) == '0) &&
      ((valid_q[k] & ~dirty_q[k] & ~txblock_q[k]) == '0)
    ) else $error("entry %0d holds an illegal byte state", k);
  end

  assign empty_o = (valid_q == '0);

endmodule

/* src/wbuf_tx_engine.sv */
// transmit side of the coalescing store buffer
// picks a sendable word and a free transaction slot with locked round-robin,
// issues the memory write, marks its bytes in flight and retires responses

`timescale 1ns/100ps

module wbuf_tx_engine (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  wbuf_pkg::wbuf_entry_t [wbuf_pkg::WBUF_DEPTH-1:0] entries_i,
  input  logic                                            mem_ack_i,
  input  logic                                            mem_rsp_valid_i,
  input  wbuf_pkg::tx_id_t                                mem_rsp_id_i,
  output logic                                            mem_req_valid_o,
  output wbuf_pkg::mem_req_t                              mem_req_o,
  output wbuf_pkg::wbuf_mark_t                            send_mark_o,
  output wbuf_pkg::wbuf_mark_t                            clear_mark_o
);

  wbuf_pkg::tx_slot_t [wbuf_pkg::NUM_TX-1:0]       slot_q;
  wbuf_pkg::tx_slot_t [wbuf_pkg::NUM_TX-1:0]       slot_d;
  wbuf_pkg::byte_mask_t [wbuf_pkg::WBUF_DEPTH-1:0] send_mask;
  logic [wbuf_pkg::WBUF_DEPTH-1:0]                 sendable;
  logic [wbuf_pkg::NUM_TX-1:0]                     free_slot;
  logic                                            rsp_valid_q;
  wbuf_pkg::tx_id_t                                rsp_id_q;
  logic                                            lock_q;
  wbuf_pkg::wbuf_ptr_t                             ent_lock_q;
  wbuf_pkg::tx_id_t                                slot_lock_q;
  wbuf_pkg::wbuf_ptr_t                             ent_rr_q;
  wbuf_pkg::tx_id_t                                slot_rr_q;
  wbuf_pkg::wbuf_ptr_t                             ent_pick;
  wbuf_pkg::wbuf_ptr_t                             slot_pick;
  wbuf_pkg::wbuf_ptr_t                             ent_sel;
  wbuf_pkg::tx_id_t                                slot_sel;
  logic                                            tx_fire;

  // first requester at or after start, wrapping around
  function automatic wbuf_pkg::wbuf_ptr_t rr_pick(
    input logic [wbuf_pkg::WBUF_DEPTH-1:0] req,
    input wbuf_pkg::wbuf_ptr_t             start
  );
    wbuf_pkg::wbuf_ptr_t idx;
    wbuf_pkg::wbuf_ptr_t pick;
    logic                found;
    pick  = start;
    found = 1'b0;
    for (int i = 0; i < wbuf_pkg::WBUF_DEPTH; i++) begin
      idx = start + wbuf_pkg::wbuf_ptr_t'(i);
      if (!found && req[idx]) begin
        pick  = idx;
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  //////////////////////////////
  // selection
  //////////////////////////////

  // a word with bytes in flight waits, a resend must not overtake the older write
  for (genvar k = 0; k < wbuf_pkg::WBUF_DEPTH; k++) begin : gen_sendable
    assign send_mask[k] = entries_i[k].valid & entries_i[k].dirty;
    assign sendable[k]  = (|send_mask[k]) & ~(|entries_i[k].txblock);
  end

  for (genvar j = 0; j < wbuf_pkg::NUM_TX; j++) begin : gen_free
    assign free_slot[j] = ~slot_q[j].valid;
  end

  assign ent_pick  = rr_pick(sendable, ent_rr_q);
  // slot vector padded up to the pointer width of the shared picker
  assign slot_pick = rr_pick({{(wbuf_pkg::WBUF_DEPTH - wbuf_pkg::NUM_TX){1'b0}}, free_slot},
                             {{(wbuf_pkg::WBUF_PTR_WIDTH - wbuf_pkg::TX_ID_WIDTH){1'b0}},
                              slot_rr_q});

  // choices freeze while a request waits for its ack
  assign ent_sel  = lock_q ? ent_lock_q : ent_pick;
  assign slot_sel = lock_q ? slot_lock_q : slot_pick[wbuf_pkg::TX_ID_WIDTH-1:0];

  //////////////////////////////
  // memory request
  //////////////////////////////

  assign mem_req_valid_o = (|sendable) & (|free_slot);
  assign tx_fire         = mem_req_valid_o & mem_ack_i;

  assign mem_req_o.id    = slot_sel;
  assign mem_req_o.addr  = entries_i[ent_sel].addr;
  assign mem_req_o.data  = entries_i[ent_sel].data;
  assign mem_req_o.mask  = send_mask[ent_sel];

  assign send_mark_o.en   = tx_fire;
  assign send_mark_o.ptr  = ent_sel;
  assign send_mark_o.mask = send_mask[ent_sel];

  // registered response clears the bytes its slot carried
  assign clear_mark_o.en   = rsp_valid_q;
  assign clear_mark_o.ptr  = slot_q[rsp_id_q].ptr;
  assign clear_mark_o.mask = slot_q[rsp_id_q].mask;

  //////////////////////////////
  // slots and pointers
  //////////////////////////////

  always_comb begin : p_slots
    slot_d = slot_q;
    if (rsp_valid_q) begin
      slot_d[rsp_id_q].valid = 1'b0;
    end
    if (tx_fire) begin
      slot_d[slot_sel].valid = 1'b1;
      slot_d[slot_sel].ptr   = ent_sel;
      slot_d[slot_sel].mask  = send_mask[ent_sel];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      slot_q      <= '0;
      rsp_valid_q <= 1'b0;
      rsp_id_q    <= '0;
      lock_q      <= 1'b0;
      ent_lock_q  <= '0;
      slot_lock_q <= '0;
      ent_rr_q    <= '0;
      slot_rr_q   <= '0;
    end else begin
      slot_q      <= slot_d;
      rsp_valid_q <= mem_rsp_valid_i;
      rsp_id_q    <= mem_rsp_id_i;
      // hold while raised and not yet acknowledged
      lock_q      <= mem_req_valid_o & ~mem_ack_i;
      ent_lock_q  <= ent_sel;
      slot_lock_q <= slot_sel;
      // fairness: next search starts behind the winner
      if (tx_fire) begin
        ent_rr_q  <= ent_sel + 1'b1;
        slot_rr_q <= slot_sel + 1'b1;
      end
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  a_rsp_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_rsp_valid_i |-> slot_q[mem_rsp_id_i].valid
  ) else $error("response for a transaction slot that is not outstanding");

  a_no_alloc_free : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (tx_fire && rsp_valid_q) |-> (slot_sel != rsp_id_q)
  ) else $error("transaction slot allocated and freed in the same cycle");

  // data and mask may still coalesce, the locked word and slot may not move
  a_req_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (mem_req_valid_o && !mem_ack_i) |=>
      (mem_req_valid_o && $stable(mem_req_o.id) && $stable(mem_req_o.addr))
  ) else $error("memory request changed before its acknowledge");

endmodule

/* src/wbuf_top.sv */
// top level of the coalescing store buffer
// store port in, split memory request and response ports out, plus an empty
// flag for draining; intake, entry array and transmit engine are wired here

`timescale 1ns/100ps

module wbuf_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // core store port, grant comes back in the same cycle
  input  logic                 store_valid_i,
  input  wbuf_pkg::store_req_t store_req_i,
  output logic                 store_gnt_o,
  // memory write requests
  output logic                 mem_req_valid_o,
  output wbuf_pkg::mem_req_t   mem_req_o,
  input  logic                 mem_ack_i,
  // memory responses, never back-pressured
  input  logic                 mem_rsp_valid_i,
  input  wbuf_pkg::tx_id_t     mem_rsp_id_i,
  output logic                 empty_o
);

  wbuf_pkg::wbuf_entry_t [wbuf_pkg::WBUF_DEPTH-1:0] entries;
  wbuf_pkg::wbuf_write_t                            wr_cmd;
  wbuf_pkg::wbuf_mark_t                             send_mark;
  wbuf_pkg::wbuf_mark_t                             clear_mark;

  //////////////////////////////
  // store side
  //////////////////////////////

  wbuf_store_intake i_store_intake (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .store_valid_i ( store_valid_i ),
    .store_req_i   ( store_req_i   ),
    .entries_i     ( entries       ),
    .store_gnt_o   ( store_gnt_o   ),
    .wr_cmd_o      ( wr_cmd        )
  );

  // shared state seen by both sides
  wbuf_entry_array i_entry_array (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .wr_cmd_i     ( wr_cmd     ),
    .send_mark_i  ( send_mark  ),
    .clear_mark_i ( clear_mark ),
    .entries_o    ( entries    ),
    .empty_o      ( empty_o    )
  );

  //////////////////////////////
  // memory side
  //////////////////////////////

  wbuf_tx_engine i_tx_engine (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .entries_i       ( entries         ),
    .mem_ack_i       ( mem_ack_i       ),
    .mem_rsp_valid_i ( mem_rsp_valid_i ),
    .mem_rsp_id_i    ( mem_rsp_id_i    ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_req_o       ( mem_req_o       ),
    .send_mark_o     ( send_mark       ),
    .clear_mark_o    ( clear_mark      )
  );

endmodule

/* testbench/tb_clock_gen.sv */
// clock and reset source for the store buffer testbench
// 10 ns clock, active low reset held for the first 16 cycles

`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HALF_PERIOD  = 5;
  localparam int RESET_CYCLES = 16;

  initial begin : p_clock
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

  // release just after an edge, like every other input
  initial begin : p_reset
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

/* testbench/tb_wbuf_top.sv */
// testbench of the coalescing store buffer
// random stores over a small word set meet a memory model with random acks
// and out-of-order responses, every write and the final image are compared

`timescale 1ns/100ps

module tb_wbuf_top;

  localparam int NUM_WORDS      = 12;
  localparam int NUM_STORES     = 600;
  localparam int TIMEOUT_CYCLES = NUM_STORES * 20 + 2000;
  // ack behaviour of the memory model
  localparam int ACK_LOW        = 0;
  localparam int ACK_RANDOM     = 1;
  localparam int ACK_HIGH       = 2;
  // grant expectation for the store driven this cycle
  localparam int GNT_ANY        = 0;
  localparam int GNT_YES        = 1;
  localparam int GNT_NO         = 2;

  logic                 clk;
  logic                 rst_n;
  logic                 store_valid;
  wbuf_pkg::store_req_t store_req;
  logic                 store_gnt;
  logic                 mem_req_valid;
  wbuf_pkg::mem_req_t   mem_req;
  logic                 mem_ack;
  logic                 mem_rsp_valid;
  wbuf_pkg::tx_id_t     mem_rsp_id;
  logic                 empty;

  // owned by the stimulus process
  logic [31:0]          lfsr_state;
  int                   ack_mode;
  int                   gnt_expect;
  logic                 drain_done;
  logic                 armed    [wbuf_pkg::NUM_TX];
  int                   rsp_wait [wbuf_pkg::NUM_TX];

  // owned by the checker process
  wbuf_pkg::word_data_t ref_mem     [NUM_WORDS];
  wbuf_pkg::byte_mask_t ref_written [NUM_WORDS];
  wbuf_pkg::word_data_t act_mem     [NUM_WORDS];
  wbuf_pkg::byte_mask_t act_written [NUM_WORDS];
  logic                 out_valid   [wbuf_pkg::NUM_TX];
  wbuf_pkg::word_addr_t out_addr    [wbuf_pkg::NUM_TX];
  logic                 reset_seen;
  int                   err_cnt;
  int                   check_cnt;
  int                   store_cnt;
  int                   req_cnt;
  int                   rsp_cnt;
  int                   cycle_cnt;

  tb_clock_gen i_clock_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  wbuf_top i_dut (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .store_valid_i   ( store_valid   ),
    .store_req_i     ( store_req     ),
    .store_gnt_o     ( store_gnt     ),
    .mem_req_valid_o ( mem_req_valid ),
    .mem_req_o       ( mem_req       ),
    .mem_ack_i       ( mem_ack       ),
    .mem_rsp_valid_i ( mem_rsp_valid ),
    .mem_rsp_id_i    ( mem_rsp_id    ),
    .empty_o         ( empty         )
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  // x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
  endfunction

  // one lfsr step for every bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val        = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  // spread the word set over unrelated addresses
  function automatic wbuf_pkg::word_addr_t word_addr_of(input int idx);
    return wbuf_pkg::word_addr_t'(32'h0040_0100 + idx * 17);
  endfunction

  function automatic int word_index(input wbuf_pkg::word_addr_t addr);
    int idx;
    idx = -1;
    for (int i = 0; i < NUM_WORDS; i++) begin
      if (word_addr_of(i) == addr) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  // reference model, a store replaces exactly its enabled bytes
  function automatic wbuf_pkg::word_data_t merge_bytes(
    input wbuf_pkg::word_data_t old_data,
    input wbuf_pkg::word_data_t new_data,
    input wbuf_pkg::byte_mask_t mask
  );
    wbuf_pkg::word_data_t res;
    res = old_data;
    for (int b = 0; b < wbuf_pkg::BYTES_PER_WORD; b++) begin
      if (mask[b]) begin
        res[b*8 +: 8] = new_data[b*8 +: 8];
      end
    end
    return res;
  endfunction

  //////////////////////////////
  // stimulus and memory model
  //////////////////////////////

  // ack per mode, then answer at most one armed transaction whose delay ran out
  task automatic drive_memory();
    int pick;
    pick = -1;
    if (ack_mode == ACK_LOW) begin
      mem_ack = 1'b0;
    end else if (ack_mode == ACK_RANDOM) begin
      mem_ack = (rand_bits(2) != 32'd0);
    end else begin
      mem_ack = 1'b1;
    end
    for (int j = 0; j < wbuf_pkg::NUM_TX; j++) begin
      if (!out_valid[j]) begin
        armed[j] = 1'b0;
      end else if (!armed[j]) begin
        // new transaction seen, response after 1 to 6 cycles
        armed[j]    = 1'b1;
        rsp_wait[j] = int'(rand_bits(3) % 32'd6) + 1;
      end
    end
    for (int j = 0; j < wbuf_pkg::NUM_TX; j++) begin
      if (armed[j] && rsp_wait[j] == 0 && pick < 0) begin
        pick = j;
      end else if (armed[j] && rsp_wait[j] > 0) begin
        rsp_wait[j]--;
      end
    end
    mem_rsp_valid = (pick >= 0);
    mem_rsp_id    = (pick >= 0) ? wbuf_pkg::tx_id_t'(pick) : '0;
  endtask

  task automatic step_cycle();
    @(posedge clk);
    #1;
    drive_memory();
    gnt_expect = GNT_ANY;
  endtask

  task automatic drive_store(input int idx, input int exp_gnt);
    wbuf_pkg::byte_mask_t mask;
    mask = wbuf_pkg::byte_mask_t'(rand_bits(8));
    if (mask == '0) begin
      mask = 8'h01;
    end
    store_valid    = 1'b1;
    store_req.addr = word_addr_of(idx);
    store_req.data = {rand_bits(32), rand_bits(32)};
    store_req.mask = mask;
    gnt_expect     = exp_gnt;
  endtask

  // no acks, so every store stays buffered until the array is full
  task automatic fill_buffer();
    ack_mode = ACK_LOW;
    for (int i = 0; i < wbuf_pkg::WBUF_DEPTH; i++) begin
      step_cycle();
      drive_store(i, GNT_YES);
    end
    step_cycle();
    drive_store(wbuf_pkg::WBUF_DEPTH, GNT_NO);
    step_cycle();
    drive_store(3, GNT_YES);
    step_cycle();
    store_valid = 1'b0;
  endtask

  // a request is held until granted, with random idle gaps between stores
  task automatic random_stores();
    ack_mode = ACK_RANDOM;
    for (int n = 0; n < NUM_STORES; n++) begin
      if (rand_bits(2) == 32'd0) begin
        store_valid = 1'b0;
        step_cycle();
      end
      drive_store(int'(rand_bits(4) % NUM_WORDS), GNT_ANY);
      @(negedge clk);
      while (store_gnt !== 1'b1) begin
        step_cycle();
        @(negedge clk);
      end
      step_cycle();
    end
    store_valid = 1'b0;
  endtask

  task automatic drain_buffer();
    ack_mode = ACK_HIGH;
    @(negedge clk);
    while (empty !== 1'b1) begin
      step_cycle();
      @(negedge clk);
    end
    step_cycle();
    drain_done = 1'b1;
  endtask

  initial begin : p_stimulus
    lfsr_state    = 32'h832d_a18b;
    store_valid   = 1'b0;
    store_req     = '0;
    mem_ack       = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_id    = '0;
    ack_mode      = ACK_LOW;
    gnt_expect    = GNT_ANY;
    drain_done    = 1'b0;
    for (int j = 0; j < wbuf_pkg::NUM_TX; j++) begin
      armed[j]    = 1'b0;
      rsp_wait[j] = 0;
    end
    wait (rst_n === 1'b1);
    // leave the first cycle idle for the reset check
    @(negedge clk);
    fill_buffer();
    random_stores();
    drain_buffer();
  end

  //////////////////////////////
  // checker
  //////////////////////////////

  task automatic check_cond(input logic ok, input string msg);
    check_cnt++;
    assert (ok) else begin
      err_cnt++;
      $display("** Error @ %0t: %s", $time, msg);
    end
  endtask

  task automatic clear_checker();
    for (int i = 0; i < NUM_WORDS; i++) begin
      ref_mem[i]     = '0;
      ref_written[i] = '0;
      act_mem[i]     = '0;
      act_written[i] = '0;
    end
    for (int j = 0; j < wbuf_pkg::NUM_TX; j++) begin
      out_valid[j] = 1'b0;
      out_addr[j]  = '0;
    end
    reset_seen = 1'b0;
    err_cnt    = 0;
    check_cnt  = 0;
    store_cnt  = 0;
    req_cnt    = 0;
    rsp_cnt    = 0;
  endtask

  // id and address unique among outstanding, data equal to the latest store
  task automatic check_request();
    int   idx;
    int   busy;
    logic clash;
    idx   = word_index(mem_req.addr);
    busy  = 0;
    clash = 1'b0;
    req_cnt++;
    for (int j = 0; j < wbuf_pkg::NUM_TX; j++) begin
      if (out_valid[j]) begin
        busy++;
        clash = clash | (out_addr[j] == mem_req.addr);
      end
    end
    check_cond(idx >= 0, $sformatf("request to unknown word %h", mem_req.addr));
    check_cond(mem_req.mask != '0, "request with an empty byte mask");
    check_cond(!out_valid[mem_req.id], $sformatf("id %0d issued twice", mem_req.id));
    check_cond(!clash, $sformatf("word %h already in flight", mem_req.addr));
    check_cond(busy < wbuf_pkg::NUM_TX, "more transactions in flight than slots");
    if (idx >= 0) begin
      for (int b = 0; b < wbuf_pkg::BYTES_PER_WORD; b++) begin
        if (mem_req.mask[b]) begin
          check_cond(ref_written[idx][b] &&
                     (mem_req.data[b*8 +: 8] == ref_mem[idx][b*8 +: 8]),
                     $sformatf("word %0d byte %0d sent as %h, expected %h", idx, b,
                               mem_req.data[b*8 +: 8], ref_mem[idx][b*8 +: 8]));
        end
      end
      act_mem[idx]     = merge_bytes(act_mem[idx], mem_req.data, mem_req.mask);
      act_written[idx] = act_written[idx] | mem_req.mask;
    end
    out_valid[mem_req.id] = 1'b1;
    out_addr[mem_req.id]  = mem_req.addr;
  endtask

  task automatic apply_store();
    int idx;
    idx = word_index(store_req.addr);
    store_cnt++;
    if (idx >= 0) begin
      ref_mem[idx]     = merge_bytes(ref_mem[idx], store_req.data, store_req.mask);
      ref_written[idx] = ref_written[idx] | store_req.mask;
    end
  endtask

  task automatic compare_images();
    for (int j = 0; j < wbuf_pkg::NUM_TX; j++) begin
      check_cond(!out_valid[j], $sformatf("id %0d still in flight after drain", j));
    end
    for (int i = 0; i < NUM_WORDS; i++) begin
      for (int b = 0; b < wbuf_pkg::BYTES_PER_WORD; b++) begin
        if (ref_written[i][b]) begin
          check_cond(act_written[i][b] && (act_mem[i][b*8 +: 8] == ref_mem[i][b*8 +: 8]),
                     $sformatf("memory word %0d byte %0d is %h, expected %h", i, b,
                               act_mem[i][b*8 +: 8], ref_mem[i][b*8 +: 8]));
        end
      end
    end
  endtask

  task automatic print_counts();
    $display("stores %0d, requests %0d, responses %0d, checks %0d, errors %0d",
             store_cnt, req_cnt, rsp_cnt, check_cnt, err_cnt);
  endtask

  task automatic finish_run();
    print_counts();
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // sample mid cycle, handshakes here complete at the next rising edge
  always @(negedge clk) begin : p_check
    if (!rst_n) begin
      clear_checker();
    end else begin
      if (!reset_seen) begin
        check_cond(store_gnt === 1'b0 && mem_req_valid === 1'b0 && empty === 1'b1,
                   "outputs not idle after reset");
        reset_seen = 1'b1;
      end
      if (gnt_expect == GNT_YES) begin
        check_cond(store_gnt === 1'b1, $sformatf("store to %h refused", store_req.addr));
      end else if (gnt_expect == GNT_NO) begin
        check_cond(store_gnt === 1'b0, $sformatf("store to %h granted", store_req.addr));
      end
      // a response retires its id before a new request may reuse it
      if (mem_rsp_valid) begin
        out_valid[mem_rsp_id] = 1'b0;
        rsp_cnt++;
      end
      // request first, a store in the same cycle lands after the send
      if (mem_req_valid && mem_ack) begin
        check_request();
      end
      if (store_valid && store_gnt) begin
        apply_store();
      end
      if (drain_done) begin
        compare_images();
        finish_run();
      end
    end
  end

  initial begin : p_watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("run did not finish within %0d cycles and was stopped", TIMEOUT_CYCLES);
    print_counts();
    $display("Simulation failed");
    $finish;
  end

endmodule

/* wbuf_top.f */
src/wbuf_pkg.sv
src/wbuf_store_intake.sv
src/wbuf_entry_array.sv
src/wbuf_tx_engine.sv
src/wbuf_top.sv
testbench/tb_clock_gen.sv
testbench/tb_wbuf_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the store buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module tb_wbuf_top \
  --Mdir obj_dir \
  -f wbuf_top.f

# the log decides the result, not the exit status of the run
./obj_dir/Vtb_wbuf_top | tee sim.log

if grep -q "^Simulation completed successfully$" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
